/* hw/asip_macros.svh */
`ifndef ASIP_MACROS_SVH
`define ASIP_MACROS_SVH

// ---------------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------------

// register, alu and data memory word
`define ASIP_DAT_W 16
// one instruction word
`define ASIP_INS_W 16

// ---------------------------------------------------------------------------
// address spaces and register file
// ---------------------------------------------------------------------------

// pc wraps at 2**ASIP_IMEM_AW
`define ASIP_IMEM_AW 8
// data address, same width as the immediate field
`define ASIP_DMEM_AW 8
// general purpose registers r0..r7
`define ASIP_REG_N 8
// first fetch address out of reset
`define ASIP_RESET_PC 0

`endif

/* hw/asip_pkg.sv */
`default_nettype none

`include "asip_macros.svh"

package asip_pkg;

	// data word and raw instruction
	typedef logic [`ASIP_DAT_W-1:0] dat_t;
	typedef logic [`ASIP_INS_W-1:0] ins_t;

	// instruction side address, also the pc
	typedef logic [`ASIP_IMEM_AW-1:0] imem_addr_t;
	// data side address, doubles as the 8 bit immediate
	typedef logic [`ASIP_DMEM_AW-1:0] dmem_addr_t;
	typedef logic [$clog2(`ASIP_REG_N)-1:0] reg_idx_t;

	// opcode in ins[15:12], anything unlisted decodes as nop
	typedef enum logic [3:0] {
		OP_NOP = 4'd0, OP_LDI = 4'd1, OP_LD = 4'd2,
		OP_ST = 4'd3, OP_ADD = 4'd4, OP_SUB = 4'd5,
		OP_MUL = 4'd6, OP_JMP = 4'd7, OP_HALT = 4'd15
	} opcode_e;

	typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_MUL} alu_op_e;

	// source of the register writeback value
	typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM} wb_sel_e;

	// multi-cycle sequencer, one instruction in flight
	typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_WB, S_HALT} core_state_e;

endpackage

`default_nettype wire

/* hw/asip_fetch.sv */
`default_nettype none

`include "asip_macros.svh"

module asip_fetch (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 t_cs,
	input  wire asip_pkg::ins_t       ins_mem_dat,
	input  wire logic                 is_jump,
	input  wire logic                 is_halt,
	input  wire logic                 mem_rd,
	input  wire asip_pkg::dmem_addr_t imm,
	output logic                      ins_mem_en_b,
	output asip_pkg::imem_addr_t      ins_mem_addr,
	output asip_pkg::ins_t            ins_reg,
	output logic                      exec_en,
	output logic                      wb_en,
	output logic                      halt
);

	import asip_pkg::*;

	core_state_e state;
	imem_addr_t  pc;

	// ------------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= S_FETCH;
			pc      <= imem_addr_t'(`ASIP_RESET_PC);
			// nop in the ir until the first fetch lands
			ins_reg <= '0;
		end else begin
			case (state)
				S_FETCH: begin
					// chip select low parks here without a request
					if (t_cs)
						state <= S_DECODE;
				end
				S_DECODE: begin
					// imem answers one cycle after the request
					ins_reg <= ins_mem_dat;
					state   <= S_EXEC;
				end
				S_EXEC: begin
					if (is_halt) begin
						state <= S_HALT;
					end else begin
						// jump target or next word with wrap at 256
						pc    <= is_jump ? imem_addr_t'(imm) : pc + 1'b1;
						// loads need one more cycle for the read data
						state <= mem_rd ? S_WB : S_FETCH;
					end
				end
				S_WB:
					state <= S_FETCH;
				default:
					// S_HALT is left only by reset
					state <= S_HALT;
			endcase
		end
	end

	// request straight from the state in the same cycle as t_cs
	assign ins_mem_en_b = ~((state == S_FETCH) & t_cs);
	assign ins_mem_addr = pc;

	// stage strobes for the memory stage
	assign exec_en = (state == S_EXEC);
	assign wb_en   = (state == S_WB);
	assign halt    = (state == S_HALT);

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------

	// fetch only from the idle state and only when selected
	a_fetch_req: assert property (@(posedge clk) disable iff (reset)
		!ins_mem_en_b |-> (state == S_FETCH) && t_cs);

endmodule

`default_nettype wire

/* hw/asip_decoder.sv */
`default_nettype none

module asip_decoder (
	input  wire asip_pkg::ins_t ins_reg,
	output asip_pkg::reg_idx_t  rd,
	output asip_pkg::reg_idx_t  rs,
	output asip_pkg::reg_idx_t  rt,
	output asip_pkg::dmem_addr_t imm,
	output asip_pkg::alu_op_e   alu_op,
	output asip_pkg::wb_sel_e   wb_sel,
	output logic                reg_wr,
	output logic                mem_rd,
	output logic                mem_wr,
	output logic                is_jump,
	output logic                is_halt
);

	import asip_pkg::*;

	opcode_e opcode;

	// field split
	// op[15:12] rd[11:9] rs[8:6] rt[5:3] with imm/addr overlapping [7:0]
	assign opcode = opcode_e'(ins_reg[15:12]);
	assign rd     = ins_reg[11:9];
	// a store reads rd on the rs port
	assign rs     = (opcode == OP_ST) ? ins_reg[11:9] : ins_reg[8:6];
	assign rt     = ins_reg[5:3];
	assign imm    = ins_reg[7:0];

	always_comb begin
		// unknown opcodes fall through with every flag low
		alu_op  = ALU_ADD;
		wb_sel  = WB_ALU;
		reg_wr  = 1'b0;
		mem_rd  = 1'b0;
		mem_wr  = 1'b0;
		is_jump = 1'b0;
		is_halt = 1'b0;
		case (opcode)
			OP_LDI: begin
				wb_sel = WB_IMM;
				reg_wr = 1'b1;
			end
			OP_LD: begin
				// rd written a cycle later from memory
				wb_sel = WB_MEM;
				reg_wr = 1'b1;
				mem_rd = 1'b1;
			end
			// rd goes out as store data over the rs bus
			OP_ST:   mem_wr = 1'b1;
			OP_ADD:  reg_wr = 1'b1;
			OP_SUB: begin
				alu_op = ALU_SUB;
				reg_wr = 1'b1;
			end
			OP_MUL: begin
				alu_op = ALU_MUL;
				reg_wr = 1'b1;
			end
			OP_JMP:  is_jump = 1'b1;
			OP_HALT: is_halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hw/asip_gprf.sv */
`default_nettype none

`include "asip_macros.svh"

module asip_gprf (
	input  wire logic               clk,
	input  wire logic               reset,
	input  wire asip_pkg::reg_idx_t rs,
	input  wire asip_pkg::reg_idx_t rt,
	input  wire logic               gprf_we,
	input  wire asip_pkg::reg_idx_t gprf_waddr,
	input  wire asip_pkg::dat_t     gprf_wdat,
	output asip_pkg::dat_t          rs_dat,
	output asip_pkg::dat_t          rt_dat
);

	import asip_pkg::*;

	dat_t regs [`ASIP_REG_N];

	// single write port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `ASIP_REG_N; i++)
				regs[i] <= '0;
		end else if (gprf_we) begin
			regs[gprf_waddr] <= gprf_wdat;
		end
	end

	// two read buses, no bypass
	// a write shows up on the next read cycle
	assign rs_dat = regs[rs];
	assign rt_dat = regs[rt];

	// an x index here would mean the ir never loaded
	a_waddr_known: assert property (@(posedge clk) disable iff (reset)
		gprf_we |-> !$isunknown(gprf_waddr));

endmodule

`default_nettype wire

/* hw/asip_alu.sv */
`default_nettype none

module asip_alu (
	input  wire asip_pkg::alu_op_e alu_op,
	input  wire asip_pkg::dat_t    a_dat,
	input  wire asip_pkg::dat_t    b_dat,
	output asip_pkg::dat_t         result
);

	import asip_pkg::*;

	// ------------------------------------------------------------------------
	// single cycle, everything mod 2**16
	// ------------------------------------------------------------------------

	always_comb begin
		case (alu_op)
			ALU_SUB:
				result = a_dat - b_dat;
			ALU_MUL:
				// 16 bit context keeps the low half of the product
				result = a_dat * b_dat;
			default:
				result = a_dat + b_dat;
		endcase
	end

endmodule

`default_nettype wire

/* hw/asip_mem_stage.sv */
`default_nettype none

module asip_mem_stage (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 exec_en,
	input  wire logic                 wb_en,
	input  wire asip_pkg::reg_idx_t   rd,
	input  wire asip_pkg::dmem_addr_t imm,
	input  wire asip_pkg::wb_sel_e    wb_sel,
	input  wire logic                 reg_wr,
	input  wire logic                 mem_rd,
	input  wire logic                 mem_wr,
	input  wire asip_pkg::dat_t       alu_result,
	input  wire asip_pkg::dat_t       st_dat,
	input  wire asip_pkg::dat_t       dat_mem_rdat,
	output logic                      dat_mem_en_b,
	output logic                      dat_mem_rw,
	output asip_pkg::dmem_addr_t      dat_mem_addr,
	output asip_pkg::dat_t            dat_mem_wdat,
	output logic                      gprf_we,
	output asip_pkg::reg_idx_t        gprf_waddr,
	output asip_pkg::dat_t            gprf_wdat
);

	import asip_pkg::*;

	logic rd_req;
	logic wr_req;
	logic ld_pend;

	// ------------------------------------------------------------------------
	// data memory port
	// ------------------------------------------------------------------------

	// one request per instruction, only in the exec cycle
	assign rd_req = exec_en & mem_rd;
	assign wr_req = exec_en & mem_wr;

	assign dat_mem_en_b = ~(rd_req | wr_req);
	// idles at read, drops to 0 only for the store cycle
	assign dat_mem_rw   = ~wr_req;
	assign dat_mem_addr = imm;
	assign dat_mem_wdat = st_dat;

	// read data arrives in the cycle after rd_req
	always_ff @(posedge clk) begin
		if (reset)
			ld_pend <= 1'b0;
		else
			ld_pend <= rd_req;
	end

	// ------------------------------------------------------------------------
	// register writeback
	// ------------------------------------------------------------------------

	// alu and ldi in exec, loads in wb
	assign gprf_we    = (exec_en & reg_wr & ~mem_rd) | (wb_en & ld_pend & reg_wr);
	assign gprf_waddr = rd;

	always_comb begin
		case (wb_sel)
			WB_IMM:  gprf_wdat = dat_t'(imm);
			WB_MEM:  gprf_wdat = dat_mem_rdat;
			default: gprf_wdat = alu_result;
		endcase
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(rd_req && wr_req));

	// the sequencer only enters wb right behind a load request
	a_wb_after_ld: assert property (@(posedge clk) disable iff (reset)
		wb_en |-> ld_pend);

endmodule

`default_nettype wire

/* hw/asip_top.sv */
`default_nettype none

module asip_top (
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic                 t_cs,
	input  wire asip_pkg::ins_t       ins_mem_dat,
	input  wire asip_pkg::dat_t       dat_mem_rdat,
	output logic                      ins_mem_en_b,
	output asip_pkg::imem_addr_t      ins_mem_addr,
	output logic                      dat_mem_en_b,
	output logic                      dat_mem_rw,
	output asip_pkg::dmem_addr_t      dat_mem_addr,
	output asip_pkg::dat_t            dat_mem_wdat,
	output logic                      halt
);

	import asip_pkg::*;

	// ------------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------------

	// fetch to decoder and memory stage
	ins_t       ins_reg;
	logic       exec_en;
	logic       wb_en;

	// decoded fields and flags
	reg_idx_t   rd;
	reg_idx_t   rs;
	reg_idx_t   rt;
	dmem_addr_t imm;
	alu_op_e    alu_op;
	wb_sel_e    wb_sel;
	logic       reg_wr;
	logic       mem_rd;
	logic       mem_wr;
	logic       is_jump;
	logic       is_halt;

	// register file and alu
	dat_t       rs_dat;
	dat_t       rt_dat;
	dat_t       alu_result;
	logic       gprf_we;
	reg_idx_t   gprf_waddr;
	dat_t       gprf_wdat;

	asip_fetch u_fetch (
		.clk, .reset, .t_cs, .ins_mem_dat, .is_jump, .is_halt, .mem_rd, .imm,
		.ins_mem_en_b, .ins_mem_addr, .ins_reg, .exec_en, .wb_en, .halt
	);

	asip_decoder u_decoder (
		.ins_reg, .rd, .rs, .rt, .imm, .alu_op, .wb_sel,
		.reg_wr, .mem_rd, .mem_wr, .is_jump, .is_halt
	);

	asip_gprf u_gprf (
		.clk, .reset, .rs, .rt, .gprf_we, .gprf_waddr, .gprf_wdat,
		.rs_dat, .rt_dat
	);

	asip_alu u_alu (
		.alu_op,
		.a_dat  (rs_dat),
		.b_dat  (rt_dat),
		.result (alu_result)
	);

	// store data rides the rs read bus
	asip_mem_stage u_mem_stage (
		.clk, .reset, .exec_en, .wb_en, .rd, .imm, .wb_sel,
		.reg_wr, .mem_rd, .mem_wr, .alu_result,
		.st_dat (rs_dat),
		.dat_mem_rdat,
		.dat_mem_en_b, .dat_mem_rw, .dat_mem_addr, .dat_mem_wdat,
		.gprf_we, .gprf_waddr, .gprf_wdat
	);

endmodule

`default_nettype wire

/* tests/asip_tb.sv */
`default_nettype none

`include "asip_macros.svh"

module asip_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import asip_pkg::*;

	localparam int IMEM_N   = 2 ** `ASIP_IMEM_AW;
	localparam int DMEM_N   = 2 ** `ASIP_DMEM_AW;
	localparam int WAIT_MAX = 400;

	logic       clk;
	logic       reset;
	logic       t_cs;
	ins_t       ins_mem_dat;
	dat_t       dat_mem_rdat;
	logic       ins_mem_en_b;
	imem_addr_t ins_mem_addr;
	logic       dat_mem_en_b;
	logic       dat_mem_rw;
	dmem_addr_t dat_mem_addr;
	dat_t       dat_mem_wdat;
	logic       halt;

	// memory arrays and request logs
	ins_t       imem [IMEM_N];
	dat_t       dmem [DMEM_N];
	imem_addr_t fetch_q [$];
	dmem_addr_t st_addr_q [$];
	dat_t       st_dat_q [$];

	int seed   = 97;
	int errors = 0;

	asip_top DUT (
		.clk, .reset, .t_cs, .ins_mem_dat, .dat_mem_rdat,
		.ins_mem_en_b, .ins_mem_addr, .dat_mem_en_b, .dat_mem_rw,
		.dat_mem_addr, .dat_mem_wdat, .halt
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// memory models
	// ------------------------------------------------------------------------

	// imem answers one cycle later and holds the word
	always @(posedge clk) begin
		if (!ins_mem_en_b) begin
			ins_mem_dat <= imem[ins_mem_addr];
			if (!reset)
				fetch_q.push_back(ins_mem_addr);
		end
	end

	// dmem reads with rw high and writes with rw low
	always @(posedge clk) begin
		if (!dat_mem_en_b) begin
			if (dat_mem_rw) begin
				dat_mem_rdat <= dmem[dat_mem_addr];
			end else begin
				dmem[dat_mem_addr] <= dat_mem_wdat;
				if (!reset) begin
					st_addr_q.push_back(dat_mem_addr);
					st_dat_q.push_back(dat_mem_wdat);
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// instruction encoding
	// ------------------------------------------------------------------------

	// add sub and mul set rd to rs op rt
	function automatic ins_t alu_word(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		return {op, rd, rs, rt, 3'b000};
	endfunction

	// ldi, ld, st, jmp and halt carry rd and an 8 bit field
	function automatic ins_t imm_word(opcode_e op, reg_idx_t rd, dmem_addr_t imm);
		return {op, rd, 1'b0, imm};
	endfunction

	// ------------------------------------------------------------------------
	// checks and failure reporting
	// ------------------------------------------------------------------------

	task automatic abort_run();
		errors++;
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(string msg);
		$display("%s (at %0t)", msg, $time);
		abort_run();
	endtask

	task automatic check_dat(dat_t got, dat_t exp, string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			abort_run();
		end
	endtask

	task automatic check_dmem_addr(dmem_addr_t got, dmem_addr_t exp, string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			abort_run();
		end
	endtask

	task automatic check_imem_addr(imem_addr_t got, imem_addr_t exp, string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
			abort_run();
		end
	endtask

	// one logged store against its expected address and data
	task automatic expect_store(int idx, dmem_addr_t a, dat_t d, string name);
		if (idx >= st_addr_q.size())
			report_failure($sformatf("%s: store %0d never happened", name, idx));
		check_dmem_addr(st_addr_q[idx], a, $sformatf("%s store %0d address", name, idx));
		check_dat(st_dat_q[idx], d, $sformatf("%s store %0d data", name, idx));
	endtask

	task automatic expect_store_count(int n, string name);
		if (st_addr_q.size() != n)
			report_failure($sformatf("%s: %0d stores seen, %0d expected",
				name, st_addr_q.size(), n));
	endtask

	// ------------------------------------------------------------------------
	// program loading and run control
	// ------------------------------------------------------------------------

	// unused imem words decode as halt with the address in the low byte
	task automatic fill_memories(ins_t prog[$]);
		for (int a = 0; a < IMEM_N; a++)
			imem[a] = {OP_HALT, 4'h0, 8'(a)};
		for (int a = 0; a < DMEM_N; a++)
			dmem[a] = {8'(a) ^ 8'hd0, 8'(a)};
		foreach (prog[i])
			imem[i] = prog[i];
	endtask

	task automatic run_core();
		@(posedge clk);
		reset <= 1'b1;
		t_cs  <= 1'b1;
		fetch_q.delete();
		st_addr_q.delete();
		st_dat_q.delete();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic wait_halt(string name);
		int n = 0;
		@(negedge clk);
		while (!halt) begin
			@(negedge clk);
			n++;
			if (n > WAIT_MAX)
				report_failure({"timeout waiting for halt in ", name});
		end
	endtask

	task automatic await_fetch_count(int count, string name);
		int n = 0;
		@(negedge clk);
		while (fetch_q.size() < count) begin
			@(negedge clk);
			n++;
			if (n > WAIT_MAX)
				report_failure({"timeout waiting for instruction fetches in ", name});
		end
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------

	task automatic ldi_then_store();
		ins_t prog[$];
		dmem_addr_t imm;
		imm  = dmem_addr_t'($random(seed));
		prog = '{imm_word(OP_LDI, 3'd1, imm), imm_word(OP_ST, 3'd1, 8'h2a),
			imm_word(OP_HALT, 3'd0, 8'h00)};
		fill_memories(prog);
		run_core();
		wait_halt("ldi_then_store");
		expect_store_count(1, "ldi_then_store");
		// zero extended immediate
		expect_store(0, 8'h2a, {8'h00, imm}, "ldi_then_store");
	endtask

	task automatic alu_random_ops();
		ins_t prog[$];
		dat_t a;
		dat_t b;
		logic [31:0] prod;
		a    = dat_t'($random(seed));
		b    = dat_t'($random(seed));
		prod = a * b;
		prog = '{imm_word(OP_LD, 3'd1, 8'h10), imm_word(OP_LD, 3'd2, 8'h11),
			alu_word(OP_ADD, 3'd3, 3'd1, 3'd2), imm_word(OP_ST, 3'd3, 8'h31),
			alu_word(OP_SUB, 3'd4, 3'd1, 3'd2), imm_word(OP_ST, 3'd4, 8'h32),
			alu_word(OP_MUL, 3'd5, 3'd1, 3'd2), imm_word(OP_ST, 3'd5, 8'h33),
			imm_word(OP_HALT, 3'd0, 8'h00)};
		fill_memories(prog);
		dmem[8'h10] = a;
		dmem[8'h11] = b;
		run_core();
		wait_halt("alu_random_ops");
		expect_store_count(3, "alu_random_ops");
		expect_store(0, 8'h31, a + b, "add");
		expect_store(1, 8'h32, a - b, "sub");
		// low half of the full product
		expect_store(2, 8'h33, prod[15:0], "mul");
	endtask

	task automatic load_and_double();
		ins_t prog[$];
		dat_t w;
		logic [16:0] dbl;
		w    = dat_t'($random(seed));
		dbl  = {w, 1'b0};
		prog = '{imm_word(OP_LD, 3'd1, 8'h20), alu_word(OP_ADD, 3'd2, 3'd1, 3'd1),
			imm_word(OP_ST, 3'd2, 8'h25), imm_word(OP_HALT, 3'd0, 8'h00)};
		fill_memories(prog);
		dmem[8'h20] = w;
		run_core();
		wait_halt("load_and_double");
		expect_store_count(1, "load_and_double");
		expect_store(0, 8'h25, dbl[15:0], "load_and_double");
	endtask

	task automatic jump_over_store();
		ins_t prog[$];
		imem_addr_t exp_fetch[$];
		dmem_addr_t imm;
		imm       = dmem_addr_t'($random(seed));
		// word 2 is the skipped store
		prog      = '{imm_word(OP_LDI, 3'd1, imm), imm_word(OP_JMP, 3'd0, 8'h03),
			imm_word(OP_ST, 3'd1, 8'h12), imm_word(OP_ST, 3'd1, 8'h13),
			imm_word(OP_HALT, 3'd0, 8'h00)};
		exp_fetch = '{8'h00, 8'h01, 8'h03, 8'h04};
		fill_memories(prog);
		run_core();
		wait_halt("jump_over_store");
		foreach (fetch_q[i])
			if (fetch_q[i] == 8'h02)
				report_failure("jump_over_store: skipped address 2 was fetched");
		if (fetch_q.size() != exp_fetch.size())
			report_failure($sformatf("jump_over_store: %0d fetches, %0d expected",
				fetch_q.size(), exp_fetch.size()));
		foreach (exp_fetch[i])
			check_imem_addr(fetch_q[i], exp_fetch[i], $sformatf("fetch %0d", i));
		expect_store_count(1, "jump_over_store");
		expect_store(0, 8'h13, {8'h00, imm}, "jump_over_store");
	endtask

	task automatic halt_and_chip_select();
		ins_t prog[$];
		dmem_addr_t v1;
		dmem_addr_t v2;
		dmem_addr_t v3;
		int n_before;
		v1   = dmem_addr_t'($random(seed));
		v2   = dmem_addr_t'($random(seed));
		v3   = dmem_addr_t'($random(seed));
		prog = '{imm_word(OP_LDI, 3'd1, v1), imm_word(OP_ST, 3'd1, 8'h01),
			imm_word(OP_LDI, 3'd2, v2), imm_word(OP_ST, 3'd2, 8'h02),
			imm_word(OP_LDI, 3'd3, v3), imm_word(OP_ST, 3'd3, 8'h03),
			imm_word(OP_HALT, 3'd0, 8'h00)};
		fill_memories(prog);
		run_core();
		await_fetch_count(3, "halt_and_chip_select");
		// deselect for six cycles mid program
		@(posedge clk);
		t_cs <= 1'b0;
		@(negedge clk);
		n_before = fetch_q.size();
		repeat (6) @(posedge clk);
		@(negedge clk);
		if (fetch_q.size() != n_before)
			report_failure("instruction request issued while t_cs was low");
		@(posedge clk);
		t_cs <= 1'b1;
		wait_halt("halt_and_chip_select");
		expect_store_count(3, "halt_and_chip_select");
		expect_store(0, 8'h01, {8'h00, v1}, "cs store a");
		expect_store(1, 8'h02, {8'h00, v2}, "cs store b");
		expect_store(2, 8'h03, {8'h00, v3}, "cs store c");
		// nothing more may be fetched once the core is parked
		n_before = fetch_q.size();
		repeat (5) @(posedge clk);
		@(negedge clk);
		if (!halt)
			report_failure("halt dropped after the core halted");
		if (fetch_q.size() != n_before)
			report_failure("instruction request issued after halt");
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		reset        = 1'b1;
		t_cs         = 1'b1;
		ins_mem_dat  = '0;
		dat_mem_rdat = '0;
		ldi_then_store();
		alu_random_ops();
		load_and_double();
		jump_over_store();
		halt_and_chip_select();
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/asip_pkg.sv
hw/asip_fetch.sv
hw/asip_decoder.sv
hw/asip_gprf.sv
hw/asip_alu.sv
hw/asip_mem_stage.sv
hw/asip_top.sv
tests/asip_tb.sv

/* Bender.yml */
package:
  name: asip

export_include_dirs:
  - hw

sources:
  - files:
      - hw/asip_pkg.sv
      - hw/asip_fetch.sv
      - hw/asip_decoder.sv
      - hw/asip_gprf.sv
      - hw/asip_alu.sv
      - hw/asip_mem_stage.sv
      - hw/asip_top.sv
  - target: simulation
    files:
      - tests/asip_tb.sv
